/* rtl/corePkg.sv */
////////////////////////////////////////////////////////////
// core widths, opcodes, funct3 and alu op codes
// instruction format union, execute control and retire structs
////////////////////////////////////////////////////////////
`default_nettype none

package corePkg;

  localparam int xLen        = 32;
  localparam int regAddrBits = 5;

  // major opcodes
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  // funct3 of the alu group
  localparam logic [2:0] f3Add = 3'b000; // add, sub, addi
  localparam logic [2:0] f3Sll = 3'b001;
  localparam logic [2:0] f3Slt = 3'b010;
  localparam logic [2:0] f3Xor = 3'b100;
  localparam logic [2:0] f3Srl = 3'b101;
  localparam logic [2:0] f3Or  = 3'b110;
  localparam logic [2:0] f3And = 3'b111;

  // funct3 of the branch group
  localparam logic [2:0] f3Beq = 3'b000;
  localparam logic [2:0] f3Bne = 3'b001;
  localparam logic [2:0] f3Blt = 3'b100;
  localparam logic [2:0] f3Bge = 3'b101;

  // alu op is {funct7 bit 5, funct3}
  localparam logic [3:0] aluAdd = {1'b0, f3Add};
  localparam logic [3:0] aluSub = {1'b1, f3Add};
  localparam logic [3:0] aluSll = {1'b0, f3Sll};
  localparam logic [3:0] aluSlt = {1'b0, f3Slt};
  localparam logic [3:0] aluXor = {1'b0, f3Xor};
  localparam logic [3:0] aluSrl = {1'b0, f3Srl};
  localparam logic [3:0] aluOr  = {1'b0, f3Or};
  localparam logic [3:0] aluAnd = {1'b0, f3And};

  ////////////////////////////////////////////////////////////
  // instruction formats

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFmtT;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iFmtT;

  typedef struct packed {
    logic       imm12;   // sign bit
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bFmtT;

  typedef struct packed {
    logic       imm20;   // sign bit
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jFmtT;

  typedef union packed {
    rFmtT r;
    iFmtT i;
    bFmtT b;
    jFmtT j;
  } instrU;

  ////////////////////////////////////////////////////////////
  // pipeline records

  typedef struct packed {
    logic                   valid;
    logic [3:0]             aluOp;    // funct3 only for branches
    logic                   useImm;
    logic                   isBranch;
    logic                   isJal;
    logic                   isLui;
    logic                   illegal;
    logic                   regWrite; // never set for rd 0
    logic [regAddrBits-1:0] rd;
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rs2;
    logic [xLen-1:0]        imm;
  } exCtrlT;

  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic [xLen-1:0]        pc;
    logic [regAddrBits-1:0] rd;
    logic [xLen-1:0]        value;
  } retireT;

endpackage

`default_nettype wire

/* rtl/fetchUnit.sv */
////////////////////////////////////////////////////////////
// fetch unit: program counter with redirect and hold
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import corePkg::*; #(
  parameter logic [xLen-1:0] resetVector = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stallAll,
  input  logic            redirect,
  input  logic [xLen-1:0] redirectTarget,
  output logic [xLen-1:0] pcF
);

  logic [xLen-1:0] pcSeq;
  logic [xLen-1:0] pcNext;

  // sequential fetch is always one word ahead
  assign pcSeq = pcF + xLen'(4);

  // a taken branch or jal in E overrides the sequential address
  always_comb begin
    if (redirect) begin
      pcNext = redirectTarget;
    end else begin
      pcNext = pcSeq;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= resetVector;
    end else if (!stallAll) begin
      pcF <= pcNext;
    end
    // held cycles keep the current address on the port
  end

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
////////////////////////////////////////////////////////////
// decoder: instruction views to execute controls and immediate
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import corePkg::*; (
  input  instrU  instr,
  input  logic   validE,
  output exCtrlT ctrl
);

  logic            legal;
  logic            writes;      // format has a destination
  logic [12:0]     branchOff;
  logic [20:0]     jumpOff;
  logic [xLen-1:0] immI;
  logic [xLen-1:0] immB;
  logic [xLen-1:0] immJ;
  logic [xLen-1:0] immU;

  // immediates, one per format
  assign branchOff = {instr.b.imm12, instr.b.imm11, instr.b.imm10to5, instr.b.imm4to1, 1'b0};
  assign jumpOff   = {instr.j.imm20, instr.j.imm19to12, instr.j.imm11, instr.j.imm10to1, 1'b0};
  assign immI      = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign immB      = {{19{branchOff[12]}}, branchOff};
  assign immJ      = {{11{jumpOff[20]}}, jumpOff};
  assign immU      = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};

  always_comb begin
    legal         = 1'b0;
    writes        = 1'b0;
    ctrl          = '0;
    ctrl.rs1      = instr.r.rs1;
    ctrl.rs2      = instr.r.rs2;
    ctrl.aluOp    = {1'b0, instr.r.funct3};

    case (instr.r.opcode)
      opReg: begin
        writes     = 1'b1;
        ctrl.aluOp = {instr.r.funct7[5], instr.r.funct3};
        if (instr.r.funct7 == 7'h00) begin
          legal = instr.r.funct3 inside {f3Add, f3Sll, f3Slt, f3Xor, f3Srl, f3Or, f3And};
        end else if (instr.r.funct7 == 7'h20) begin
          legal = (instr.r.funct3 == f3Add); // sub
        end
      end
      opImm: begin
        writes      = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.imm    = immI;
        legal       = instr.i.funct3 inside {f3Add, f3Slt, f3Xor, f3Or, f3And};
      end
      opLui: begin
        writes     = 1'b1;
        ctrl.isLui = 1'b1;
        ctrl.imm   = immU;
        legal      = 1'b1;
      end
      opBranch: begin
        ctrl.isBranch = 1'b1;
        ctrl.imm      = immB;
        legal         = instr.b.funct3 inside {f3Beq, f3Bne, f3Blt, f3Bge};
      end
      opJal: begin
        writes     = 1'b1;
        ctrl.isJal = 1'b1;
        ctrl.imm   = immJ;
        legal      = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    // bubbles and illegal words do nothing
    ctrl.valid    = validE;
    ctrl.illegal  = validE & ~legal;
    ctrl.isBranch = ctrl.isBranch & validE & legal;
    ctrl.isJal    = ctrl.isJal & validE & legal;
    ctrl.regWrite = validE & legal & writes & (instr.r.rd != '0);
    ctrl.rd       = ctrl.regWrite ? instr.r.rd : '0;
  end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
////////////////////////////////////////////////////////////
// integer register file, 2 read ports and 1 write port
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module regFile import corePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [regAddrBits-1:0] rs1,
  input  logic [regAddrBits-1:0] rs2,
  input  logic                   writeEn,
  input  logic [regAddrBits-1:0] rd,
  input  logic [xLen-1:0]        writeData,
  output logic [xLen-1:0]        readA,
  output logic [xLen-1:0]        readB
);

  logic [xLen-1:0] regs [2**regAddrBits];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**regAddrBits; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && rd != '0) begin
      regs[rd] <= writeData; // x0 never written
    end
  end

  assign readA = (rs1 == '0) ? '0 : regs[rs1];
  assign readB = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/executeUnit.sv */
////////////////////////////////////////////////////////////
// execute: operand forwarding, alu, branch compare, W register
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module executeUnit import corePkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            stallAll,
  input  exCtrlT          ctrl,
  input  logic [xLen-1:0] pcE,
  input  logic [xLen-1:0] readA,
  input  logic [xLen-1:0] readB,
  input  logic            fwdA,
  input  logic            fwdB,
  output logic            redirect,
  output logic [xLen-1:0] redirectTarget,
  output retireT          retire
);

  retireT          retireQ;   // W stage
  retireT          retireNext;
  logic [xLen-1:0] srcA;
  logic [xLen-1:0] srcB;
  logic [xLen-1:0] opB;
  logic [xLen-1:0] aluResult;
  logic [xLen-1:0] result;
  logic            lessThan;
  logic            equal;
  logic            taken;

  ////////////////////////////////////////////////////////////
  // operands

  assign srcA = fwdA ? retireQ.value : readA;
  assign srcB = fwdB ? retireQ.value : readB;
  assign opB  = ctrl.useImm ? ctrl.imm : srcB;

  // shared by slt and the branch compare
  assign lessThan = $signed(srcA) < $signed(opB);
  assign equal    = (srcA == opB);

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  aluResult = srcA + opB;
      aluSub:  aluResult = srcA - opB;
      aluSll:  aluResult = srcA << opB[4:0];
      aluSlt:  aluResult = {{(xLen-1){1'b0}}, lessThan};
      aluXor:  aluResult = srcA ^ opB;
      aluSrl:  aluResult = srcA >> opB[4:0];
      aluOr:   aluResult = srcA | opB;
      aluAnd:  aluResult = srcA & opB;
      default: aluResult = '0;
    endcase
  end

  // lui passes the immediate, jal writes the link address
  always_comb begin
    if (ctrl.isLui) begin
      result = ctrl.imm;
    end else if (ctrl.isJal) begin
      result = pcE + xLen'(4);
    end else begin
      result = aluResult;
    end
  end

  ////////////////////////////////////////////////////////////
  // branch resolution

  always_comb begin
    case (ctrl.aluOp[2:0])
      f3Beq:   taken = equal;
      f3Bne:   taken = ~equal;
      f3Blt:   taken = lessThan;
      f3Bge:   taken = ~lessThan;
      default: taken = 1'b0;
    endcase
  end

  assign redirect       = (ctrl.isBranch & taken) | ctrl.isJal;
  assign redirectTarget = pcE + ctrl.imm;

  ////////////////////////////////////////////////////////////
  // writeback register

  always_comb begin
    retireNext.valid   = ctrl.valid;
    retireNext.illegal = ctrl.illegal;
    retireNext.pc      = pcE;
    retireNext.rd      = ctrl.rd;
    retireNext.value   = ctrl.regWrite ? result : '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retireQ <= '0;
    end else if (!stallAll) begin
      retireQ <= retireNext;
    end
  end

  // a held W entry reports once, after the hold ends
  always_comb begin
    retire       = retireQ;
    retire.valid = retireQ.valid & ~stallAll;
  end

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
////////////////////////////////////////////////////////////
// hazard unit: forwarding selects, E flush, global stall
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import corePkg::*; (
  input  logic   holdCore,
  input  logic   redirect,
  input  exCtrlT ctrl,
  input  retireT retire,
  output logic   fwdA,
  output logic   fwdB,
  output logic   flushE,
  output logic   stallAll
);

  logic wbWrites;

  // external hold is the only stall source
  assign stallAll = holdCore;

  // W result not yet in the register file
  assign wbWrites = retire.valid & (retire.rd != '0);

  assign fwdA = wbWrites & (retire.rd == ctrl.rs1);
  assign fwdB = wbWrites & (retire.rd == ctrl.rs2);

  // squash the word fetched next to a taken branch or jal
  assign flushE = redirect & ~holdCore;

endmodule

`default_nettype wire

/* rtl/pipelinedCore.sv */
////////////////////////////////////////////////////////////
// top level: fetch to execute register and unit instances
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module pipelinedCore import corePkg::*; #(
  parameter logic [xLen-1:0] resetVector = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            holdCore,
  input  logic [xLen-1:0] instrData,
  output logic [xLen-1:0] instrAddr,
  output retireT          retire
);

  logic [xLen-1:0] pcF;
  logic [xLen-1:0] pcE;
  instrU           instrE;
  logic            validE;
  exCtrlT          ctrlE;
  logic [xLen-1:0] readA;
  logic [xLen-1:0] readB;
  logic            fwdA;
  logic            fwdB;
  logic            flushE;
  logic            stallAll;
  logic            redirect;
  logic [xLen-1:0] redirectTarget;

  assign instrAddr = pcF;

  fetchUnit #(.resetVector(resetVector)) fetch (
    .clk, .reset, .stallAll, .redirect, .redirectTarget, .pcF);

  ////////////////////////////////////////////////////////////
  // F to E register

  always_ff @(posedge clk) begin
    if (reset) begin
      validE <= 1'b0;
    end else if (flushE) begin
      validE <= 1'b0;  // bubble
    end else if (!stallAll) begin
      validE <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallAll) begin
      instrE <= instrData;
      pcE    <= pcF;
    end
  end

  ////////////////////////////////////////////////////////////
  // execute stage

  instrDecoder decode (.instr(instrE), .validE, .ctrl(ctrlE));

  regFile regs (
    .clk, .reset,
    .rs1(ctrlE.rs1), .rs2(ctrlE.rs2),
    .writeEn(retire.valid), .rd(retire.rd), .writeData(retire.value), // from W
    .readA, .readB);

  executeUnit execute (
    .clk, .reset, .stallAll, .ctrl(ctrlE), .pcE,
    .readA, .readB, .fwdA, .fwdB,
    .redirect, .redirectTarget, .retire);

  hazardUnit hazard (
    .holdCore, .redirect, .ctrl(ctrlE), .retire,
    .fwdA, .fwdB, .flushE, .stallAll);

endmodule

`default_nettype wire

/* testbench/pipelinedCore_properties.sv */
////////////////////////////////////////////////////////////
// concurrent checks on the core ports, bound to the top level
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module coreProperties import corePkg::*; #(
  parameter logic [xLen-1:0] resetVector = '0
) (
  input logic            clk,
  input logic            reset,
  input logic            holdCore,
  input logic [xLen-1:0] instrAddr,
  input retireT          retire
);

  // quiet while held, and once reset has lasted a cycle
  property quietWhenHeld;
    @(posedge clk) (holdCore || (reset && $past(reset))) |-> !retire.valid;
  endproperty

  property startAtVector;
    @(posedge clk) reset |=> (instrAddr == resetVector);
  endproperty

  property illegalHasNoRd;
    @(posedge clk) (retire.valid && retire.illegal) |-> (retire.rd == '0);
  endproperty

  assert property (quietWhenHeld) else $error("retire strobe during hold or reset");
  assert property (startAtVector) else $error("fetch address not at reset vector after reset");
  assert property (illegalHasNoRd) else $error("illegal instruction retired with nonzero rd");

endmodule

bind pipelinedCore coreProperties #(.resetVector(resetVector)) props (
  .clk, .reset, .holdCore, .instrAddr, .retire);

`default_nettype wire

/* testbench/coreTb.sv */
////////////////////////////////////////////////////////////
// core testbench: program table, memory model, random hold,
// retire checks against the expected sequence, watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module coreTb import corePkg::*; ();

  localparam int          progLen        = 35;
  localparam int          halfPeriod     = 5;
  localparam int          watchdogCycles = progLen * 4 + 50;
  localparam logic [31:0] nopWord        = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic [31:0] word;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        illegal;
  } progEntryT;

  logic        clk;
  logic        reset;
  logic        holdCore;
  logic [31:0] instrData;
  logic [31:0] instrAddr;
  retireT      retire;

  progEntryT   progTable [progLen];
  // program indices in retire order, pc is index times 4
  int          retireSeq [$] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16,
                                 17, 18, 20, 21, 23, 24, 26, 29, 30, 31, 33, 34};
  int          seqPos;
  int          errorCount;
  int          fillIdx;
  logic [31:0] lfsrState;
  logic        bitA;
  logic        bitB;

  pipelinedCore #(.resetVector(32'h0)) uut (
    .clk, .reset, .holdCore, .instrData, .instrAddr, .retire);

  always #halfPeriod clk = ~clk;

  // instruction memory, nop past the end of the program
  assign instrData = (instrAddr < 32'(4 * progLen)) ? progTable[instrAddr[7:2]].word : nopWord;

  ////////////////////////////////////////////////////////////
  // RV32I encoders

  function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input int f3, input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] encLui(input int upper, input int rd);
    return {upper[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] encB(input int off, input int rs2, input int rs1, input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////
  // program with expected rd and value per entry

  task automatic addInstr(input logic [31:0] word, input int rd, input logic [31:0] value,
                          input bit illegal = 1'b0);
    progTable[fillIdx] = '{word: word, rd: rd[4:0], value: value, illegal: illegal};
    fillIdx++;
  endtask

  task automatic loadProgram();
    fillIdx = 0;
    addInstr(encI(5, 0, 0, 1), 1, 5);                 // addi x1
    addInstr(encI(-3, 0, 0, 2), 2, -3);               // addi x2, negative
    addInstr(encR(0, 2, 1, 0, 3), 3, 2);              // add, x2 forwarded
    addInstr(encR(32, 1, 2, 0, 4), 4, -8);            // sub
    addInstr(encR(0, 1, 4, 2, 5), 5, 1);              // slt -8 < 5
    addInstr(encR(0, 2, 1, 2, 6), 6, 0);              // slt 5 < -3
    addInstr(encI(-1, 2, 2, 7), 7, 1);                // slti -3 < -1
    addInstr(encR(0, 5, 1, 1, 8), 8, 10);             // sll by 1
    addInstr(encR(0, 1, 2, 5, 9), 9, 32'h07FF_FFFF);  // srl by 5
    addInstr(encR(0, 9, 8, 4, 10), 10, 32'h07FF_FFF5);
    addInstr(encR(0, 1, 10, 6, 11), 11, 32'h07FF_FFF5);
    addInstr(encI('hFF, 11, 7, 12), 12, 32'hF5);      // andi
    addInstr(encI('h0F, 12, 4, 13), 13, 32'hFA);      // xori
    addInstr(encI('h700, 0, 6, 14), 14, 32'h700);     // ori
    addInstr(encLui('h12345, 15), 15, 32'h1234_5000);
    addInstr(encI('h678, 15, 0, 15), 15, 32'h1234_5678);
    addInstr(encI(7, 1, 0, 0), 0, 0);                 // write to x0
    addInstr(encR(0, 1, 0, 0, 16), 16, 5);            // x0 reads zero
    addInstr(encB(8, 1, 1, 0), 0, 0);                 // beq taken
    addInstr(encI(99, 0, 0, 17), 17, 99);             // squashed
    addInstr(encB(8, 1, 1, 1), 0, 0);                 // bne not taken
    addInstr(encB(8, 1, 2, 4), 0, 0);                 // blt taken
    addInstr(encI(98, 0, 0, 17), 17, 98);             // squashed
    addInstr(encB(8, 1, 2, 5), 0, 0);                 // bge not taken
    addInstr(encB(8, 2, 1, 5), 0, 0);                 // bge taken
    addInstr(encI(97, 0, 0, 17), 17, 97);             // squashed
    addInstr(encJ(12, 18), 18, 108);                  // jal, link pc+4
    addInstr(encI(96, 0, 0, 17), 17, 96);             // squashed
    addInstr(encI(95, 0, 0, 17), 17, 95);             // never fetched
    addInstr(32'hFFFF_FFFF, 0, 0, 1'b1);              // unknown opcode, rd field 31
    addInstr(encR(0, 16, 18, 0, 19), 19, 113);
    addInstr(encJ(8, 0), 0, 0);                       // jal x0
    addInstr(encI(94, 0, 0, 17), 17, 94);             // squashed
    addInstr(encI(-13, 19, 0, 20), 20, 100);
    addInstr(encR(0, 1, 31, 0, 21), 21, 5);           // x31 untouched
  endtask

  ////////////////////////////////////////////////////////////
  // random hold source

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic drawBit(output logic b);
    b = lfsrState[0];
    lfsrState = lfsrNext(lfsrState);
  endtask

  ////////////////////////////////////////////////////////////
  // checks

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      errorCount++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic checkRetire(input int idx);
    progEntryT want;
    want = progTable[idx];
    checkField("retire.pc", retire.pc, 32'(idx * 4));
    checkField("retire.rd", 32'(retire.rd), 32'(want.rd));
    checkField("retire.value", retire.value, want.value);
    checkField("retire.illegal", 32'(retire.illegal), 32'(want.illegal));
  endtask

  always @(posedge clk) begin
    if (reset) begin
      assert (retire.valid !== 1'b1) else begin
        errorCount++;
        $display("retire strobe seen during reset at %0t ns", $time);
      end
    end else if (retire.valid === 1'b1 && seqPos < retireSeq.size()) begin
      checkRetire(retireSeq[seqPos]);
      seqPos++;
    end
  end

  task automatic endRun();
    $display("checked %0d of %0d retires, %0d errors", seqPos, retireSeq.size(), errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and watchdog

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    holdCore   = 1'b0;
    seqPos     = 0;
    errorCount = 0;
    lfsrState  = 32'd79;
    loadProgram();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (seqPos < retireSeq.size()) begin
      @(negedge clk);
      drawBit(bitA);
      drawBit(bitB);
      holdCore = bitA & bitB; // held about a quarter of the cycles
    end
    endRun();
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    errorCount++;
    $display("timeout: only %0d of %0d instructions retired", seqPos, retireSeq.size());
    endRun();
  end

endmodule

`default_nettype wire

/* list.f */
rtl/corePkg.sv
rtl/fetchUnit.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/hazardUnit.sv
rtl/pipelinedCore.sv
testbench/pipelinedCore_properties.sv
testbench/coreTb.sv

/* Makefile */
# Verilator build and run of the core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= coreTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: simulate clean

# pass only if the run prints the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJDIR)
